/* Bender.yml */
package:
  name: cp0

sources:
  # shared package first
  - common/cp0_pkg.sv
  - cp0/cp0_irq.sv
  - cp0/cp0_regs.sv
  - verilog/exc_arbiter.sv
  - verilog/cp0_top.sv
  - target: test
    files:
      - dv/cp0_tb.sv

/* all.f */
common/cp0_pkg.sv
cp0/cp0_irq.sv
cp0/cp0_regs.sv
verilog/exc_arbiter.sv
verilog/cp0_top.sv
dv/cp0_tb.sv

/* common/cp0_pkg.sv */
// cp0 shared definitions
package cp0_pkg;

	// basic widths
	localparam int CP0_WORD_W = 32;
	localparam int CP0_ADDR_W = 5;
	localparam int CP0_NR_REG = 32;
	localparam int IRQ_W = 8;
	localparam int EXT_IRQ_W = 6;
	localparam int EXC_CODE_W = 5;

	typedef logic [CP0_WORD_W-1:0] cp0_word_t;
	typedef logic [CP0_ADDR_W-1:0] cp0_addr_t;
	// one bit per cause ip bit, 15 down to 8
	typedef logic [IRQ_W-1:0] irq_vec_t;

	// implemented register addresses
	localparam cp0_addr_t CP0_BADVADDR = 5'd8;
	localparam cp0_addr_t CP0_COUNT = 5'd9;
	localparam cp0_addr_t CP0_COMPARE = 5'd11;
	localparam cp0_addr_t CP0_STATUS = 5'd12;
	localparam cp0_addr_t CP0_CAUSE = 5'd13;
	localparam cp0_addr_t CP0_EPC = 5'd14;
	localparam cp0_addr_t CP0_EBASE = 5'd15;
	// sentinel address, no write this cycle
	localparam cp0_addr_t CP0_REG_NONE = 5'd31;

	// status and cause field positions
	localparam int STATUS_IE = 0;
	localparam int STATUS_EXL = 1;
	localparam int STATUS_IM_LSB = 8;
	localparam int CAUSE_IP_LSB = 8;
	localparam int CAUSE_EXC_LSB = 2;
	// timer shares the top hardware line with ext_int[5]
	localparam int TIMER_LINE = 7;

	// general exception vector, offset from ebase
	localparam int EBASE_LSB = 12;
	localparam cp0_word_t EXC_VECTOR_OFFSET = 32'h0000_0180;

	typedef enum logic [EXC_CODE_W-1:0] {
		EC_INT = 5'd0,
		EC_ADEL = 5'd4,
		EC_ADES = 5'd5,
		EC_SYS = 5'd8,
		EC_BP = 5'd9,
		EC_RI = 5'd10,
		EC_OV = 5'd12,
		EC_NONE = 5'd31
	} exc_code_t;

	// registers the irq unit and arbiter need to see
	typedef struct packed {
		cp0_word_t status;
		cp0_word_t cause;
		cp0_word_t count;
		cp0_word_t compare;
	} cp0_view_t;

	// exception request into the bank, EC_NONE when idle
	typedef struct packed {
		exc_code_t code;
		irq_vec_t ip;
		cp0_word_t epc;
		cp0_word_t badvaddr;
	} exc_req_t;

	// synchronous exception from the pipeline
	typedef struct packed {
		exc_code_t code;
		cp0_word_t pc;
		cp0_word_t badvaddr;
	} pipe_exc_t;

endpackage

/* cp0/cp0_irq.sv */
// cp0 interrupt unit
`timescale 1ns/1ps

module cp0_irq (
	input logic clk,
	input logic rst,
	input logic [cp0_pkg::EXT_IRQ_W-1:0] ext_int,
	input cp0_pkg::cp0_view_t view,
	output cp0_pkg::irq_vec_t irq_lines,
	output logic irq_req
);

	// two flop synchronizer on the asynchronous lines
	logic [cp0_pkg::EXT_IRQ_W-1:0] sync_q1;
	logic [cp0_pkg::EXT_IRQ_W-1:0] sync_q2;

	logic timer_eq;
	logic timer_hit;
	cp0_pkg::irq_vec_t pending;
	cp0_pkg::irq_vec_t im;
	logic ie;
	logic exl;

	// compare of zero means the timer is off
	assign timer_eq = (view.count == view.compare) && (view.compare != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
			timer_hit <= 1'b0;
		end else begin
			sync_q1 <= ext_int;
			sync_q2 <= sync_q1;
			timer_hit <= timer_eq;
		end
	end

	// hardware lines sit on ip7..ip2, software bits stay zero
	always_comb begin
		irq_lines = {sync_q2, {(cp0_pkg::IRQ_W - cp0_pkg::EXT_IRQ_W){1'b0}}};
		irq_lines[cp0_pkg::TIMER_LINE] = irq_lines[cp0_pkg::TIMER_LINE] | timer_hit;
	end

	assign im = view.status[cp0_pkg::STATUS_IM_LSB +: cp0_pkg::IRQ_W];
	assign ie = view.status[cp0_pkg::STATUS_IE];
	assign exl = view.status[cp0_pkg::STATUS_EXL];

	// live lines plus what cause still holds, so a timer hit
	// survives after count has moved past compare
	assign pending = irq_lines | view.cause[cp0_pkg::CAUSE_IP_LSB +: cp0_pkg::IRQ_W];

	// only requested when interrupts are on and not already in a handler
	assign irq_req = (|(pending & im)) && ie && !exl;

endmodule

/* cp0/cp0_regs.sv */
// cp0 register bank
`timescale 1ns/1ps

module cp0_regs (
	input logic clk,
	input logic rst,
	input logic count_en,
	input cp0_pkg::cp0_addr_t wr_addr,
	input cp0_pkg::cp0_word_t wr_data,
	input cp0_pkg::cp0_addr_t rd_addr,
	output cp0_pkg::cp0_word_t rd_data,
	input logic eret,
	input cp0_pkg::irq_vec_t irq_lines,
	input cp0_pkg::exc_req_t exc_req,
	output cp0_pkg::cp0_view_t view,
	output logic exc_jmp_flag,
	output cp0_pkg::cp0_word_t exc_jmp_dest
);

	// full 32 entry bank, unimplemented entries just store what is written
	cp0_pkg::cp0_word_t regs [cp0_pkg::CP0_NR_REG];

	logic exl;
	logic exc_take;
	logic exc_load;
	logic sw_wr;
	logic cmp_wr;
	logic ip7_held;
	cp0_pkg::irq_vec_t ip_next;
	cp0_pkg::cp0_word_t vec_dest;

	assign exl = regs[cp0_pkg::CP0_STATUS][cp0_pkg::STATUS_EXL];

	// any request other than EC_NONE jumps
	assign exc_take = exc_req.code != cp0_pkg::EC_NONE;
	// state is only saved when not already in exception level
	assign exc_load = exc_take && !exl;

	// software write only when nothing of higher priority is going on
	assign sw_wr = !exc_take && !eret && (wr_addr != cp0_pkg::CP0_REG_NONE);
	assign cmp_wr = sw_wr && (wr_addr == cp0_pkg::CP0_COMPARE);

	assign ip7_held = regs[cp0_pkg::CP0_CAUSE][cp0_pkg::CAUSE_IP_LSB + cp0_pkg::TIMER_LINE];

	// next value of cause ip
	always_comb begin
		if (exc_load) begin
			ip_next = exc_req.ip;
		end else begin
			ip_next = irq_lines;
		end
		// timer bit is sticky until software rewrites compare
		// a hit in the same cycle as the write still wins
		ip_next[cp0_pkg::TIMER_LINE] = ip_next[cp0_pkg::TIMER_LINE] | (ip7_held && !cmp_wr);
	end

	// kseg1 style top bits, ebase page plus the general vector offset
	assign vec_dest = {2'b10, 30'(cp0_pkg::EXC_VECTOR_OFFSET)
		+ {regs[cp0_pkg::CP0_EBASE][29:cp0_pkg::EBASE_LSB], {cp0_pkg::EBASE_LSB{1'b0}}}};

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < cp0_pkg::CP0_NR_REG; i++) begin
				regs[i] <= '0;
			end
			exc_jmp_flag <= 1'b0;
			exc_jmp_dest <= '0;
		end else begin
			// jump flag is a single cycle pulse
			exc_jmp_flag <= 1'b0;

			if (count_en) begin
				regs[cp0_pkg::CP0_COUNT] <= regs[cp0_pkg::CP0_COUNT] + 32'd1;
			end

			// interrupt lines land in cause every cycle
			regs[cp0_pkg::CP0_CAUSE][cp0_pkg::CAUSE_IP_LSB +: cp0_pkg::IRQ_W] <= ip_next;

			if (exc_take) begin
				// nested exception only redirects, epc keeps the first pc
				if (!exl) begin
					regs[cp0_pkg::CP0_EPC] <= exc_req.epc;
					regs[cp0_pkg::CP0_BADVADDR] <= exc_req.badvaddr;
					regs[cp0_pkg::CP0_CAUSE][cp0_pkg::CAUSE_EXC_LSB +: cp0_pkg::EXC_CODE_W]
						<= exc_req.code;
					regs[cp0_pkg::CP0_STATUS][cp0_pkg::STATUS_EXL] <= 1'b1;
				end
				exc_jmp_flag <= 1'b1;
				exc_jmp_dest <= vec_dest;
			end else if (eret) begin
				// return to the saved pc and leave exception level
				regs[cp0_pkg::CP0_STATUS][cp0_pkg::STATUS_EXL] <= 1'b0;
				exc_jmp_flag <= 1'b1;
				exc_jmp_dest <= regs[cp0_pkg::CP0_EPC];
			end else if (sw_wr) begin
				// last assignment, so a write to count or cause overrides the above
				regs[wr_addr] <= wr_data;
			end
		end
	end

	// read port shows stored state only
	assign rd_data = regs[rd_addr];

	assign view.status = regs[cp0_pkg::CP0_STATUS];
	assign view.cause = regs[cp0_pkg::CP0_CAUSE];
	assign view.count = regs[cp0_pkg::CP0_COUNT];
	assign view.compare = regs[cp0_pkg::CP0_COMPARE];

endmodule

/* dv/cp0_tb.sv */
// cp0 subsystem testbench
`timescale 1ns/1ps

module cp0_tb;

	logic clk;
	logic rst;
	logic count_en;
	logic [cp0_pkg::EXT_IRQ_W-1:0] ext_int;
	cp0_pkg::cp0_addr_t wr_addr;
	cp0_pkg::cp0_word_t wr_data;
	cp0_pkg::cp0_addr_t rd_addr;
	cp0_pkg::cp0_word_t rd_data;
	logic eret;
	cp0_pkg::pipe_exc_t pipe_exc;
	logic exc_jmp_flag;
	cp0_pkg::cp0_word_t exc_jmp_dest;

	// galois lfsr state for test data
	logic [31:0] lfsr_state = 32'h07963161;
	// values carried from one test to the next
	cp0_pkg::cp0_word_t ebase_val;
	cp0_pkg::cp0_word_t epc_val;

	cp0_top u_dut (
		.clk(clk),
		.rst(rst),
		.count_en(count_en),
		.ext_int(ext_int),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.eret(eret),
		.pipe_exc(pipe_exc),
		.exc_jmp_flag(exc_jmp_flag),
		.exc_jmp_dest(exc_jmp_dest)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// one lfsr step per bit
	// taps for x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_bits(input int nbits);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
			val = {val[30:0], lfsr_state[0]};
		end
		return val;
	endfunction

	// kseg1 top bits, ebase page, general vector offset
	function automatic logic [31:0] exc_vector(input logic [31:0] ebase);
		return {2'b10, ebase[29:12], 12'h180};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
			$display("tests failed");
			$fatal(1);
		end
	endtask

	// inputs change 1 ns after the rising edge
	task automatic tick;
		@(posedge clk);
		#1;
	endtask

	task automatic write_reg(input cp0_pkg::cp0_addr_t addr, input logic [31:0] data);
		tick();
		wr_addr = addr;
		wr_data = data;
		tick();
		wr_addr = cp0_pkg::CP0_REG_NONE;
	endtask

	task automatic read_reg(input cp0_pkg::cp0_addr_t addr, output logic [31:0] val);
		tick();
		rd_addr = addr;
		@(negedge clk);
		val = rd_data;
	endtask

	task automatic read_check(input cp0_pkg::cp0_addr_t addr, input logic [31:0] exp,
			input string name);
		logic [31:0] val;
		read_reg(addr, val);
		check_value(name, val, exp);
	endtask

	// readback in the cycle right after the write edge
	task automatic write_then_read(input cp0_pkg::cp0_addr_t addr, input logic [31:0] data,
			input string name);
		write_reg(addr, data);
		rd_addr = addr;
		@(negedge clk);
		check_value(name, rd_data, data);
	endtask

	task automatic wait_jump(input string what, input int limit);
		for (int i = 0; i < limit; i++) begin
			@(negedge clk);
			if (exc_jmp_flag) begin
				return;
			end
		end
		$display("timeout while waiting for the %s", what);
		$display("tests failed");
		$fatal(1);
	endtask

	// flag must drop in the cycle after the jump
	task automatic single_pulse;
		@(negedge clk);
		check_value("exc_jmp_flag", exc_jmp_flag, 1'b0);
	endtask

	// one cycle strobe of a pipeline exception
	task automatic raise_exception(input cp0_pkg::exc_code_t code, input logic [31:0] pc,
			input logic [31:0] bad);
		tick();
		pipe_exc.code = code;
		pipe_exc.pc = pc;
		pipe_exc.badvaddr = bad;
		tick();
		pipe_exc.code = cp0_pkg::EC_NONE;
	endtask

	task automatic reset_values;
		cp0_pkg::cp0_addr_t addrs [7];
		addrs = '{5'd8, 5'd9, 5'd11, 5'd12, 5'd13, 5'd14, 5'd15};
		foreach (addrs[i]) begin
			read_check(addrs[i], 32'h0, $sformatf("reg %0d after reset", addrs[i]));
			check_value("exc_jmp_flag", exc_jmp_flag, 1'b0);
		end
	endtask

	task automatic write_readback;
		logic [31:0] cmp_val;
		ebase_val = lfsr_bits(32);
		write_then_read(cp0_pkg::CP0_EBASE, ebase_val, "ebase");
		epc_val = lfsr_bits(32);
		write_then_read(cp0_pkg::CP0_EPC, epc_val, "epc");
		cmp_val = lfsr_bits(32);
		write_then_read(cp0_pkg::CP0_COMPARE, cmp_val, "compare");
		// sentinel address with fresh data must leave the bank alone
		write_reg(cp0_pkg::CP0_REG_NONE, lfsr_bits(32));
		read_check(cp0_pkg::CP0_EPC, epc_val, "epc after sentinel write");
		read_check(cp0_pkg::CP0_COMPARE, cmp_val, "compare after sentinel write");
		read_check(cp0_pkg::CP0_REG_NONE, 32'h0, "reg 31 after sentinel write");
	endtask

	task automatic count_steps;
		logic [31:0] start;
		logic [31:0] now;
		logic [31:0] step;
		int n;
		read_reg(cp0_pkg::CP0_COUNT, start);
		n = 0;
		for (int i = 0; i < 24; i++) begin
			tick();
			step = lfsr_bits(1);
			count_en = step[0];
			if (count_en) begin
				n++;
			end
		end
		tick();
		count_en = 1'b0;
		read_reg(cp0_pkg::CP0_COUNT, now);
		check_value("count", now, start + 32'(n));
	endtask

	task automatic sync_exception;
		logic [31:0] pc;
		logic [31:0] bad;
		logic [31:0] val;
		pc = lfsr_bits(32);
		bad = lfsr_bits(32);
		raise_exception(cp0_pkg::EC_SYS, pc, bad);
		wait_jump("syscall jump", 10);
		check_value("exc_jmp_dest", exc_jmp_dest, exc_vector(ebase_val));
		single_pulse();
		read_check(cp0_pkg::CP0_EPC, pc, "epc");
		read_check(cp0_pkg::CP0_BADVADDR, bad, "badvaddr");
		read_reg(cp0_pkg::CP0_CAUSE, val);
		check_value("cause exccode", val[6:2], cp0_pkg::EC_SYS);
		read_reg(cp0_pkg::CP0_STATUS, val);
		check_value("status exl", val[1], 1'b1);
		epc_val = pc;
		// nested exception redirects only
		raise_exception(cp0_pkg::EC_SYS, ~pc, bad);
		wait_jump("nested syscall jump", 10);
		check_value("exc_jmp_dest", exc_jmp_dest, exc_vector(ebase_val));
		single_pulse();
		read_check(cp0_pkg::CP0_EPC, epc_val, "epc after nested exception");
	endtask

	task automatic eret_return;
		logic [31:0] val;
		tick();
		eret = 1'b1;
		tick();
		eret = 1'b0;
		wait_jump("eret jump", 10);
		check_value("exc_jmp_dest", exc_jmp_dest, epc_val);
		single_pulse();
		read_reg(cp0_pkg::CP0_STATUS, val);
		check_value("status exl", val[1], 1'b0);
	endtask

	task automatic timer_and_masking;
		logic [31:0] c;
		logic [31:0] val;
		// ie and im7 only
		write_reg(cp0_pkg::CP0_STATUS, 32'h0000_8001);
		read_reg(cp0_pkg::CP0_COUNT, c);
		write_reg(cp0_pkg::CP0_COMPARE, c + 32'd3);
		tick();
		count_en = 1'b1;
		wait_jump("timer interrupt", 20);
		check_value("exc_jmp_dest", exc_jmp_dest, exc_vector(ebase_val));
		tick();
		count_en = 1'b0;
		read_reg(cp0_pkg::CP0_CAUSE, val);
		check_value("cause ip7", val[15], 1'b1);
		check_value("cause exccode", val[6:2], cp0_pkg::EC_INT);
		write_reg(cp0_pkg::CP0_COMPARE, c + 32'h1000);
		read_reg(cp0_pkg::CP0_CAUSE, val);
		check_value("cause ip7 after compare write", val[15], 1'b0);
		// leave exception level with line 2 still masked
		write_reg(cp0_pkg::CP0_STATUS, 32'h0000_8001);
		tick();
		ext_int = 6'b000001;
		for (int i = 0; i < 12; i++) begin
			@(negedge clk);
			check_value("exc_jmp_flag on masked line", exc_jmp_flag, 1'b0);
		end
		read_reg(cp0_pkg::CP0_CAUSE, val);
		check_value("cause ip2", val[10], 1'b1);
		tick();
		ext_int = '0;
	endtask

	initial begin
		rst = 1'b1;
		count_en = 1'b0;
		ext_int = '0;
		wr_addr = cp0_pkg::CP0_REG_NONE;
		wr_data = '0;
		rd_addr = '0;
		eret = 1'b0;
		pipe_exc.code = cp0_pkg::EC_NONE;
		pipe_exc.pc = '0;
		pipe_exc.badvaddr = '0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		reset_values();
		write_readback();
		count_steps();
		sync_exception();
		eret_return();
		timer_and_masking();
		$display("all tests passed");
		$finish;
	end

endmodule

/* verilog/cp0_top.sv */
// cp0 subsystem top
`timescale 1ns/1ps

module cp0_top (
	input logic clk,
	input logic rst,
	input logic count_en,
	input logic [cp0_pkg::EXT_IRQ_W-1:0] ext_int,
	// software access
	input cp0_pkg::cp0_addr_t wr_addr,
	input cp0_pkg::cp0_word_t wr_data,
	input cp0_pkg::cp0_addr_t rd_addr,
	output cp0_pkg::cp0_word_t rd_data,
	// pipeline side
	input logic eret,
	input cp0_pkg::pipe_exc_t pipe_exc,
	output logic exc_jmp_flag,
	output cp0_pkg::cp0_word_t exc_jmp_dest
);

	cp0_pkg::cp0_view_t view;
	cp0_pkg::irq_vec_t irq_lines;
	logic irq_req;
	cp0_pkg::exc_req_t exc_req;

	cp0_irq u_irq (
		.clk(clk),
		.rst(rst),
		.ext_int(ext_int),
		.view(view),
		.irq_lines(irq_lines),
		.irq_req(irq_req)
	);

	// flag feeds back for the hold-off cycle
	exc_arbiter u_arb (
		.clk(clk),
		.rst(rst),
		.pipe_exc(pipe_exc),
		.irq_req(irq_req),
		.irq_lines(irq_lines),
		.exc_jmp_flag(exc_jmp_flag),
		.exc_req(exc_req)
	);

	cp0_regs u_regs (
		.clk(clk),
		.rst(rst),
		.count_en(count_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.eret(eret),
		.irq_lines(irq_lines),
		.exc_req(exc_req),
		.view(view),
		.exc_jmp_flag(exc_jmp_flag),
		.exc_jmp_dest(exc_jmp_dest)
	);

endmodule

/* verilog/exc_arbiter.sv */
// exception request arbiter
`timescale 1ns/1ps

module exc_arbiter (
	input logic clk,
	input logic rst,
	input cp0_pkg::pipe_exc_t pipe_exc,
	input logic irq_req,
	input cp0_pkg::irq_vec_t irq_lines,
	input logic exc_jmp_flag,
	output cp0_pkg::exc_req_t exc_req
);

	logic exc_pending;
	logic src_active;
	logic emit;
	// set once a request goes out, dropped when its source goes away
	logic taking_q;
	cp0_pkg::exc_req_t req_sel;

	assign exc_pending = pipe_exc.code != cp0_pkg::EC_NONE;
	assign src_active = irq_req || exc_pending;

	// quiet while the previous jump is issued or its source still holds
	assign emit = src_active && !exc_jmp_flag && !taking_q;

	always_comb begin
		req_sel.ip = irq_lines;
		// interrupt is taken at the current instruction
		req_sel.epc = pipe_exc.pc;
		if (irq_req) begin
			// interrupt beats a pipeline exception in the same cycle
			req_sel.code = cp0_pkg::EC_INT;
			req_sel.badvaddr = '0;
		end else begin
			req_sel.code = pipe_exc.code;
			req_sel.badvaddr = pipe_exc.badvaddr;
		end
	end

	always_comb begin
		exc_req = req_sel;
		if (!emit) begin
			exc_req.code = cp0_pkg::EC_NONE;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			taking_q <= 1'b0;
		end else if (emit) begin
			taking_q <= 1'b1;
		end else if (!src_active) begin
			taking_q <= 1'b0;
		end
	end

endmodule
